/* Bender.yml */
package:
  name: integer_alu

sources:
  # Packages first, then the RTL
  - files:
      - hw/alu_op_pkg.sv
      - hw/alu_data_pkg.sv
      - hw/int_arith_unit.sv
      - hw/int_to_float.sv
      - hw/float_to_int.sv
      - hw/integer_alu.sv

  # Testbench, monitor and bound assertions
  - target: test
    files:
      - tests/integer_alu_chk.sv
      - tests/alu_monitor.sv
      - tests/integer_alu_tb.sv

/* hw/alu_data_pkg.sv */
////////////////////
// Integer ALU data types
// Word sizes, flags, operand bundle, IEEE single fields
////////////////////
`default_nettype none

package alu_data_pkg;

    localparam int WORD_W     = 32;
    localparam int HALF_W     = WORD_W / 2;
    localparam int POS_W      = $clog2(WORD_W);

    // IEEE single precision layout
    localparam int EXP_W      = 8;
    localparam int MAN_W      = 23;
    localparam int FLOAT_BIAS = 127;

    localparam logic [WORD_W-1:0] INT_MAX = {1'b0, {(WORD_W-1){1'b1}}};
    localparam logic [WORD_W-1:0] INT_MIN = {1'b1, {(WORD_W-1){1'b0}}};

    typedef struct packed {
        logic overflow;
        logic zero;
    } alu_flags_t;

    typedef struct packed {
        logic signed [WORD_W-1:0] op1;
        logic signed [WORD_W-1:0] op2;
    } alu_operands_t;

    typedef struct packed {
        logic             sign;
        logic [EXP_W-1:0] exponent;
        logic [MAN_W-1:0] mantissa;
    } float_word_t;

endpackage

`default_nettype wire

/* hw/alu_op_pkg.sv */
////////////////////
// Integer ALU operation codes
// Operation word union, read as a raw code or as special/group/sel
////////////////////
`default_nettype none

package alu_op_pkg;

    localparam int OP_W = 4;

    // Group 00, arithmetic
    localparam logic [OP_W-1:0] OP_ADD        = 4'd0;
    localparam logic [OP_W-1:0] OP_SUB        = 4'd1;
    localparam logic [OP_W-1:0] OP_MUL        = 4'd2;
    localparam logic [OP_W-1:0] OP_DIV        = 4'd3;

    // Group 01, bitwise logic
    localparam logic [OP_W-1:0] OP_NOT        = 4'd4;
    localparam logic [OP_W-1:0] OP_AND        = 4'd5;
    localparam logic [OP_W-1:0] OP_OR         = 4'd6;
    localparam logic [OP_W-1:0] OP_XOR        = 4'd7;

    // Group 1x, special operations
    localparam logic [OP_W-1:0] OP_WRITE_HIGH = 4'd8;
    localparam logic [OP_W-1:0] OP_WRITE_LOW  = 4'd9;
    localparam logic [OP_W-1:0] OP_ITOF       = 4'd10;
    localparam logic [OP_W-1:0] OP_FTOI       = 4'd11;

    // Field view of the operation word, msb first
    typedef struct packed {
        logic       special;
        logic       group;
        logic [1:0] sel;
    } alu_op_fields_t;

    typedef union packed {
        logic [OP_W-1:0] code;
        alu_op_fields_t  f;
    } alu_op_u;

endpackage

`default_nettype wire

/* hw/float_to_int.sv */
////////////////////
// IEEE single to int32, one stage
// Truncates toward zero, saturates out of range
////////////////////
`timescale 1ns/1ps
`default_nettype none

module float_to_int import alu_data_pkg::*; (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     en,
    input  float_word_t              operand,
    output logic signed [WORD_W-1:0] result,
    output logic                     done
);

    logic                     armed;
    logic                     start;
    logic                     is_nan;
    logic [EXP_W-1:0]         shift;
    logic [WORD_W-1:0]        sig;
    logic [WORD_W-1:0]        mag;
    logic signed [WORD_W-1:0] conv;

    assign start = en && armed;

    always_comb begin
        is_nan = (&operand.exponent) && (operand.mantissa != '0);
        shift  = operand.exponent - EXP_W'(FLOAT_BIAS);
        // Significand with the hidden one restored
        sig    = {{(WORD_W-MAN_W-1){1'b0}}, 1'b1, operand.mantissa};
        mag    = '0;
        if (is_nan) begin
            conv = INT_MAX;
        end else if (operand.exponent < FLOAT_BIAS) begin
            conv = '0;
        end else if (operand.exponent >= FLOAT_BIAS + WORD_W - 1) begin
            // Includes infinity and exactly -2^31
            conv = operand.sign ? INT_MIN : INT_MAX;
        end else begin
            if (shift >= MAN_W) begin
                mag = sig << (shift - EXP_W'(MAN_W));
            end else begin
                mag = sig >> (EXP_W'(MAN_W) - shift);
            end
            conv = operand.sign ? WORD_W'(-mag) : mag;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            armed <= 1'b1;
            done  <= 1'b0;
        end else begin
            if (!en) begin
                armed <= 1'b1;
            end else if (start) begin
                armed <= 1'b0;
            end
            done <= start;
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            result <= conv;
        end
    end

endmodule

`default_nettype wire

/* hw/int_arith_unit.sv */
////////////////////
// Signed add, subtract, multiply in one cycle
// Signed restoring divide over 32 steps
// Overflow and zero flags
////////////////////
`timescale 1ns/1ps
`default_nettype none

module int_arith_unit import alu_op_pkg::*, alu_data_pkg::*; (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     en,
    input  logic [1:0]               sel,
    input  alu_operands_t            operands,
    output logic signed [WORD_W-1:0] result,
    output alu_flags_t               flags,
    output logic                     done
);

    logic                       armed;
    logic                       busy;
    logic                       start;
    logic [POS_W-1:0]           step_cnt;

    // Single cycle path
    logic signed [WORD_W-1:0]   a;
    logic signed [WORD_W-1:0]   b;
    logic signed [2*WORD_W-1:0] prod;
    logic signed [WORD_W-1:0]   fast_res;
    logic                       fast_ovf;

    // Divider state, magnitudes only
    logic [WORD_W-1:0]          quo;
    logic [WORD_W-1:0]          dvs;
    logic [WORD_W-1:0]          rem;
    logic                       div_neg;
    logic                       div_by_zero;
    logic [WORD_W:0]            rem_shift;
    logic [WORD_W+1:0]          rem_diff;
    logic [WORD_W-1:0]          quo_next;
    logic [WORD_W-1:0]          rem_next;
    logic signed [WORD_W-1:0]   div_res;
    logic                       div_ovf;

    assign start = en && armed && !busy;

    always_comb begin
        a        = operands.op1;
        b        = operands.op2;
        prod     = a * b;
        fast_res = '0;
        fast_ovf = 1'b0;
        case (sel)
            OP_ADD[1:0]: begin
                fast_res = a + b;
                fast_ovf = (a[WORD_W-1] == b[WORD_W-1]) && (fast_res[WORD_W-1] != a[WORD_W-1]);
            end
            OP_SUB[1:0]: begin
                fast_res = a - b;
                fast_ovf = (a[WORD_W-1] != b[WORD_W-1]) && (fast_res[WORD_W-1] != a[WORD_W-1]);
            end
            OP_MUL[1:0]: begin
                fast_res = prod[WORD_W-1:0];
                // Upper half must be pure sign extension
                fast_ovf = prod[2*WORD_W-1:WORD_W-1] != {(WORD_W+1){prod[WORD_W-1]}};
            end
            default: begin
                fast_res = '0;
                fast_ovf = 1'b0;
            end
        endcase
    end

    // One restoring step: shift in next dividend bit, try subtract
    always_comb begin
        rem_shift = {rem, quo[WORD_W-1]};
        rem_diff  = {1'b0, rem_shift} - {2'b00, dvs};
        if (!rem_diff[WORD_W+1]) begin
            rem_next = rem_diff[WORD_W-1:0];
            quo_next = {quo[WORD_W-2:0], 1'b1};
        end else begin
            rem_next = rem_shift[WORD_W-1:0];
            quo_next = {quo[WORD_W-2:0], 1'b0};
        end

        div_res = div_neg ? WORD_W'(-quo_next) : quo_next;
        // Positive quotient of 2^31 only comes from MIN / -1
        div_ovf = !div_neg && quo_next[WORD_W-1];
        if (div_by_zero) begin
            div_res = '0;
            div_ovf = 1'b1;
        end
    end

    ////////////////////
    // Control
    ////////////////////
    always_ff @(posedge clk) begin
        if (reset) begin
            armed    <= 1'b1;
            busy     <= 1'b0;
            done     <= 1'b0;
            step_cnt <= '0;
        end else begin
            done <= 1'b0;
            if (!en) begin
                armed <= 1'b1;
            end else if (start) begin
                armed <= 1'b0;
            end

            if (start && sel == OP_DIV[1:0]) begin
                busy     <= 1'b1;
                step_cnt <= '0;
            end else if (start) begin
                done <= 1'b1;
            end else if (busy) begin
                step_cnt <= step_cnt + 1'b1;
                if (&step_cnt) begin
                    busy <= 1'b0;
                    done <= 1'b1;
                end
            end
        end
    end

    ////////////////////
    // Datapath
    ////////////////////
    always_ff @(posedge clk) begin
        if (start) begin
            if (sel == OP_DIV[1:0]) begin
                quo         <= a[WORD_W-1] ? WORD_W'(-a) : WORD_W'(a);
                dvs         <= b[WORD_W-1] ? WORD_W'(-b) : WORD_W'(b);
                rem         <= '0;
                div_neg     <= a[WORD_W-1] ^ b[WORD_W-1];
                div_by_zero <= (b == '0);
            end else begin
                result <= fast_res;
                flags  <= '{overflow: fast_ovf, zero: (fast_res == '0)};
            end
        end else if (busy) begin
            quo <= quo_next;
            rem <= rem_next;
            // Last step writes the signed quotient
            if (&step_cnt) begin
                result <= div_res;
                flags  <= '{overflow: div_ovf, zero: (div_res == '0)};
            end
        end
    end

endmodule

`default_nettype wire

/* hw/int_to_float.sv */
////////////////////
// int32 to IEEE single, two stages
// Round to nearest even
////////////////////
`timescale 1ns/1ps
`default_nettype none

module int_to_float import alu_data_pkg::*; (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     en,
    input  logic signed [WORD_W-1:0] operand,
    output float_word_t              result,
    output logic                     done
);

    logic              armed;
    logic              start;
    logic              s1_valid;

    // Stage 1
    logic [WORD_W-1:0] mag;
    logic [POS_W-1:0]  lead;
    logic [WORD_W-1:0] mag_q;
    logic [POS_W-1:0]  lead_q;
    logic              sign_q;
    logic              zero_q;

    // Stage 2
    logic [WORD_W-1:0] norm;
    logic              round_up;
    logic [MAN_W:0]    mant_sum;
    logic [EXP_W-1:0]  exp_biased;

    assign start = en && armed && !s1_valid;

    always_comb begin
        mag  = operand[WORD_W-1] ? WORD_W'(-operand) : WORD_W'(operand);
        lead = '0;
        for (int i = 0; i < WORD_W; i++) begin
            if (mag[i]) begin
                lead = POS_W'(i);
            end
        end
    end

    // Leading one moved to the msb, then guard/sticky rounding
    always_comb begin
        norm       = mag_q << (POS_W'(WORD_W - 1) - lead_q);
        round_up   = norm[WORD_W-2-MAN_W]
                     & ((|norm[WORD_W-3-MAN_W:0]) | norm[WORD_W-1-MAN_W]);
        mant_sum   = {1'b0, norm[WORD_W-2 -: MAN_W]} + (MAN_W+1)'(round_up);
        // Mantissa carry bumps the exponent
        exp_biased = EXP_W'(lead_q) + EXP_W'(FLOAT_BIAS) + EXP_W'(mant_sum[MAN_W]);
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            armed    <= 1'b1;
            s1_valid <= 1'b0;
            done     <= 1'b0;
        end else begin
            if (!en) begin
                armed <= 1'b1;
            end else if (start) begin
                armed <= 1'b0;
            end
            s1_valid <= start;
            done     <= s1_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            mag_q  <= mag;
            lead_q <= lead;
            sign_q <= operand[WORD_W-1];
            zero_q <= (operand == '0);
        end
        if (s1_valid) begin
            if (zero_q) begin
                result <= '0;
            end else begin
                result <= '{sign: sign_q, exponent: exp_biased, mantissa: mant_sum[MAN_W-1:0]};
            end
        end
    end

endmodule

`default_nettype wire

/* hw/integer_alu.sv */
////////////////////
// Integer ALU top level
// Operation decode, logic and half-word operations
// Steering of the arithmetic and conversion units
////////////////////
`timescale 1ns/1ps
`default_nettype none

module integer_alu import alu_op_pkg::*, alu_data_pkg::*; (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     en,
    input  alu_op_u                  operation,
    input  logic signed [WORD_W-1:0] op1,
    input  logic signed [WORD_W-1:0] op2,
    output logic signed [WORD_W-1:0] out,
    output alu_flags_t               flag,
    output logic                     done,
    output logic                     en_knock_down
);

    alu_operands_t            operands;
    logic                     arith_en;
    logic                     itof_en;
    logic                     ftoi_en;
    logic                     arith_done;
    logic                     itof_done;
    logic                     ftoi_done;
    logic signed [WORD_W-1:0] arith_result;
    logic signed [WORD_W-1:0] ftoi_result;
    float_word_t              itof_result;

    assign operands = '{op1: op1, op2: op2};

    int_arith_unit i_arith (
        .clk      (clk),
        .reset    (reset),
        .en       (arith_en),
        .sel      (operation.f.sel),
        .operands (operands),
        .result   (arith_result),
        .flags    (flag),
        .done     (arith_done)
    );

    int_to_float i_itof (
        .clk     (clk),
        .reset   (reset),
        .en      (itof_en),
        .operand (operands.op1),
        .result  (itof_result),
        .done    (itof_done)
    );

    float_to_int i_ftoi (
        .clk     (clk),
        .reset   (reset),
        .en      (ftoi_en),
        .operand (float_word_t'(operands.op1)),
        .result  (ftoi_result),
        .done    (ftoi_done)
    );

    ////////////////////
    // Decode and result mux
    ////////////////////
    always_comb begin
        arith_en      = 1'b0;
        itof_en       = 1'b0;
        ftoi_en       = 1'b0;
        done          = 1'b0;
        en_knock_down = 1'b0;
        out           = op1;

        if (!operation.f.special && !operation.f.group) begin
            // Multicycle arithmetic
            arith_en      = en;
            en_knock_down = en;
            done          = arith_done;
            out           = arith_result;
        end else if (!operation.f.special) begin
            // Logic ops answer at once
            done          = 1'b1;
            en_knock_down = 1'b1;
            case (operation.code)
                OP_NOT:  out = ~op1;
                OP_AND:  out = op1 & op2;
                OP_OR:   out = op1 | op2;
                OP_XOR:  out = op1 ^ op2;
                default: out = op1;
            endcase
        end else begin
            case (operation.f.sel)
                OP_WRITE_HIGH[1:0]: begin
                    done          = 1'b1;
                    en_knock_down = 1'b1;
                    out           = {op2[HALF_W-1:0], op1[HALF_W-1:0]};
                end
                OP_WRITE_LOW[1:0]: begin
                    done          = 1'b1;
                    en_knock_down = 1'b1;
                    out           = {op1[WORD_W-1:HALF_W], op2[HALF_W-1:0]};
                end
                OP_ITOF[1:0]: begin
                    itof_en       = en;
                    en_knock_down = en;
                    done          = itof_done;
                    out           = itof_result;
                end
                default: begin
                    ftoi_en       = en;
                    en_knock_down = en;
                    done          = ftoi_done;
                    out           = ftoi_result;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* sim.f */
hw/alu_op_pkg.sv
hw/alu_data_pkg.sv
hw/int_arith_unit.sv
hw/int_to_float.sv
hw/float_to_int.sv
hw/integer_alu.sv
tests/integer_alu_chk.sv
tests/alu_monitor.sv
tests/integer_alu_tb.sv

/* tests/alu_monitor.sv */
////////////////////
// Reference model of the integer ALU
// Checks out, flag, en_knock_down, latency and done once per request
////////////////////
`timescale 1ns/1ps
`default_nettype none

module alu_monitor import alu_op_pkg::*, alu_data_pkg::*; (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     en,
    input  alu_op_u                  operation,
    input  logic signed [WORD_W-1:0] op1,
    input  logic signed [WORD_W-1:0] op2,
    input  logic signed [WORD_W-1:0] out,
    input  alu_flags_t               flag,
    input  logic                     done,
    input  logic                     en_knock_down,
    output int                       error_count
);

    int                errors = 0;
    int                wait_cnt;
    logic              served;
    logic              multi;
    logic [OP_W-1:0]   code;
    logic [WORD_W-1:0] exp_out;
    alu_flags_t        exp_flag;

    assign error_count = errors;

    // Exact double, then rounded down to single precision (nearest even)
    function automatic logic [WORD_W-1:0] int_to_single(input logic signed [WORD_W-1:0] v);
        logic [63:0] d;
        logic [28:0] rest;
        logic [23:0] man;
        logic [10:0] e;
        logic        up;
        if (v == 0) begin
            return '0;
        end
        d    = $realtobits($itor(v));
        rest = d[28:0];
        up   = (rest > 29'h1000_0000) || (rest == 29'h1000_0000 && d[29]);
        man  = {1'b0, d[51:29]} + 24'(up);
        e    = d[62:52] - 11'd1023 + 11'd127 + 11'(man[23]);
        return {d[63], e[7:0], man[22:0]};
    endfunction

    function automatic logic [WORD_W-1:0] single_to_int(input float_word_t f);
        logic [63:0] d;
        real         r;
        if (f.exponent == 8'hff) begin
            if (f.mantissa != '0) begin
                return INT_MAX;
            end
            return f.sign ? INT_MIN : INT_MAX;
        end
        // Denormals are far below one
        if (f.exponent == '0) begin
            return '0;
        end
        d = {f.sign, 11'(f.exponent) - 11'd127 + 11'd1023, f.mantissa, 29'd0};
        r = $bitstoreal(d);
        if (r >= 2147483648.0) begin
            return INT_MAX;
        end
        if (r <= -2147483648.0) begin
            return INT_MIN;
        end
        return $rtoi(r);
    endfunction

    task automatic model(input logic [OP_W-1:0] c, input logic signed [WORD_W-1:0] a,
                         input logic signed [WORD_W-1:0] b,
                         output logic [WORD_W-1:0] r, output alu_flags_t fl);
        longint wide;
        fl = '0;
        case (c)
            OP_ADD, OP_SUB, OP_MUL: begin
                if (c == OP_ADD) begin
                    wide = longint'(a) + longint'(b);
                end else if (c == OP_SUB) begin
                    wide = longint'(a) - longint'(b);
                end else begin
                    wide = longint'(a) * longint'(b);
                end
                r           = wide[WORD_W-1:0];
                fl.overflow = (wide != longint'($signed(r)));
            end
            OP_DIV: begin
                if (b == 0) begin
                    r           = '0;
                    fl.overflow = 1'b1;
                end else if (a == $signed(INT_MIN) && b == -1) begin
                    r           = INT_MIN;
                    fl.overflow = 1'b1;
                end else begin
                    r = a / b;
                end
            end
            OP_NOT:        r = ~a;
            OP_AND:        r = a & b;
            OP_OR:         r = a | b;
            OP_XOR:        r = a ^ b;
            OP_WRITE_HIGH: r = {b[HALF_W-1:0], a[HALF_W-1:0]};
            OP_WRITE_LOW:  r = {a[WORD_W-1:HALF_W], b[HALF_W-1:0]};
            OP_ITOF:       r = int_to_single(a);
            default:       r = single_to_int(float_word_t'(a));
        endcase
        fl.zero = (r == '0);
    endtask

    function automatic int latency_of(input logic [OP_W-1:0] c);
        case (c)
            OP_DIV:  return 33;
            OP_ITOF: return 2;
            default: return 1;
        endcase
    endfunction

    task automatic report_value(input string name, input logic [WORD_W-1:0] exp_v,
                                input logic [WORD_W-1:0] act_v);
        $display("CHECK FAILED time %0t: %s expected %h, actual %h (operation %0d)",
                 $time, name, exp_v, act_v, code);
        errors++;
    endtask

    ////////////////////
    // Sampled mid-cycle
    ////////////////////
    always @(negedge clk) begin
        if (reset) begin
            served   = 1'b0;
            wait_cnt = 0;
        end else begin
            code  = operation.code;
            multi = (code <= OP_DIV) || (code == OP_ITOF) || (code == OP_FTOI);
            if (en_knock_down !== (multi ? en : 1'b1)) begin
                report_value("en_knock_down", multi ? en : 1'b1, en_knock_down);
            end
            if (!multi && done !== 1'b1) begin
                $display("Combinational operation %0d left done low at %0t", code, $time);
                errors++;
            end
            if (!multi || !en) begin
                served   = 1'b0;
                wait_cnt = 0;
            end else if (done === 1'b1) begin
                if (served) begin
                    $display("A second done came at %0t while en was still held", $time);
                    errors++;
                end else if (wait_cnt != latency_of(code)) begin
                    $display("Operation %0d took %0d cycles instead of %0d at %0t",
                             code, wait_cnt, latency_of(code), $time);
                    errors++;
                end
                served = 1'b1;
            end else if (!served) begin
                wait_cnt++;
            end
            if (done === 1'b1) begin
                model(code, op1, op2, exp_out, exp_flag);
                if (out !== exp_out) begin
                    report_value("out", exp_out, out);
                end
                // Flags only mean something for arithmetic
                if (code <= OP_DIV && flag !== exp_flag) begin
                    report_value("flag", exp_flag, flag);
                end
            end
        end
    end

endmodule

`default_nettype wire

/* tests/integer_alu_chk.sv */
////////////////////
// Concurrent assertions bound to the ALU top level
////////////////////
`timescale 1ns/1ps
`default_nettype none

module integer_alu_chk import alu_op_pkg::*, alu_data_pkg::*; (
    input logic                     clk,
    input logic                     reset,
    input logic                     en,
    input alu_op_u                  operation,
    input logic signed [WORD_W-1:0] out,
    input logic                     done,
    input logic                     en_knock_down
);

    int   assert_errors = 0;
    logic div_req;

    assign div_req = en && (operation.code == OP_DIV);

    out_known: assert property (@(posedge clk) disable iff (reset)
        done |-> !$isunknown(out))
        else begin
            assert_errors++;
            $error("out has unknown bits while done is high");
        end

    // 33 cycles for the divider, one spare
    div_bounded: assert property (@(posedge clk) disable iff (reset)
        $rose(div_req) |-> ##[1:34] done)
        else begin
            assert_errors++;
            $error("divide did not finish within 34 cycles");
        end

    knock_down_on_done: assert property (@(posedge clk) disable iff (reset)
        done |-> en_knock_down)
        else begin
            assert_errors++;
            $error("done high without en_knock_down");
        end

endmodule

`default_nettype wire

/* tests/integer_alu_tb.sv */
////////////////////
// Integer ALU testbench
// Clock, reset, seeded random operations, watchdog
////////////////////
`timescale 1ns/1ps
`default_nettype none

module integer_alu_tb import alu_op_pkg::*, alu_data_pkg::*; ();

    localparam int NUM_TESTS   = 400;
    localparam int TEST_CYCLES = 36;
    localparam int CLK_PERIOD  = 100;
    localparam int DRIVE_DELAY = 1;
    localparam int DONE_LIMIT  = 40;
    localparam int WATCHDOG_NS = (NUM_TESTS * TEST_CYCLES + 200) * CLK_PERIOD;

    logic                     clk;
    logic                     reset;
    logic                     en;
    alu_op_u                  operation;
    logic signed [WORD_W-1:0] op1;
    logic signed [WORD_W-1:0] op2;
    logic signed [WORD_W-1:0] out;
    alu_flags_t               flag;
    logic                     done;
    logic                     en_knock_down;
    int                       monitor_errors;
    int                       seed;
    int                       tests_run;
    int                       tb_errors;
    int                       total_errors;

    integer_alu i_dut (
        .clk           (clk),
        .reset         (reset),
        .en            (en),
        .operation     (operation),
        .op1           (op1),
        .op2           (op2),
        .out           (out),
        .flag          (flag),
        .done          (done),
        .en_knock_down (en_knock_down)
    );

    alu_monitor i_monitor (
        .clk           (clk),
        .reset         (reset),
        .en            (en),
        .operation     (operation),
        .op1           (op1),
        .op2           (op2),
        .out           (out),
        .flag          (flag),
        .done          (done),
        .en_knock_down (en_knock_down),
        .error_count   (monitor_errors)
    );

    bind integer_alu integer_alu_chk i_chk (
        .clk           (clk),
        .reset         (reset),
        .en            (en),
        .operation     (operation),
        .out           (out),
        .done          (done),
        .en_knock_down (en_knock_down)
    );

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    // Zero, minus one, extremes and small values mixed with plain random
    function automatic logic [WORD_W-1:0] pick_operand();
        int kind;
        kind = $unsigned($random(seed)) % 8;
        case (kind)
            0:       return '0;
            1:       return '1;
            2:       return INT_MIN;
            3:       return INT_MAX;
            4:       return $random(seed) % 9;
            default: return $random(seed);
        endcase
    endfunction

    function automatic logic [WORD_W-1:0] pick_float();
        float_word_t f;
        int          kind;
        f    = $random(seed);
        kind = $unsigned($random(seed)) % 8;
        case (kind)
            0: begin
                f.exponent    = 8'hff;
                f.mantissa[0] = 1'b1;
            end
            1: begin
                f.exponent = 8'hff;
                f.mantissa = '0;
            end
            2:       f.exponent = 8'(158 + $unsigned($random(seed)) % 97);
            3:       f.exponent = 8'($unsigned($random(seed)) % 127);
            4:       f.exponent = 8'd157;
            5:       f = 32'hcf00_0000;
            default: f.exponent = 8'(127 + $unsigned($random(seed)) % 31);
        endcase
        return f;
    endfunction

    function automatic logic is_multicycle(input alu_op_u op);
        if (op.f.special) begin
            return op.f.sel[1];
        end
        return !op.f.group;
    endfunction

    task automatic run_test();
        alu_op_u           op;
        logic [WORD_W-1:0] a;
        logic [WORD_W-1:0] b;
        logic              corner;
        int                waited;
        int                extra;
        op.code = 4'($unsigned($random(seed)) % 12);
        a       = (op.code == OP_FTOI) ? pick_float() : pick_operand();
        b       = pick_operand();
        // Corners that plain random seldom reaches
        corner  = ($unsigned($random(seed)) % 4) == 0;
        if (corner && op.code == OP_DIV) begin
            a = INT_MIN;
            b = '1;
        end else if (corner && op.code == OP_ITOF) begin
            // Exactly halfway between two singles
            a = {2'b01, a[29:7], 7'h40};
        end
        @(posedge clk);
        #DRIVE_DELAY;
        operation = op;
        op1       = a;
        op2       = b;
        if (is_multicycle(op)) begin
            en     = 1'b1;
            waited = 0;
            do begin
                @(negedge clk);
                waited++;
            end while (!done && waited < DONE_LIMIT);
            if (!done) begin
                $display("Operation %0d never raised done within %0d cycles", op.code, DONE_LIMIT);
                tb_errors++;
            end
            // Hold the request past done for a while
            extra = $unsigned($random(seed)) % 3;
            repeat (extra + 1) @(posedge clk);
            #DRIVE_DELAY;
            en = 1'b0;
        end else begin
            en = $random(seed);
            @(negedge clk);
        end
        tests_run++;
    endtask

    initial begin
        seed           = 32'hc1c9521f;
        reset          = 1'b1;
        en             = 1'b0;
        operation.code = OP_ADD;
        op1            = '0;
        op2            = '0;
        tests_run      = 0;
        tb_errors      = 0;
        repeat (3) @(posedge clk);
        #DRIVE_DELAY;
        reset = 1'b0;
        repeat (NUM_TESTS) run_test();
        @(posedge clk);
        @(negedge clk);
        total_errors = monitor_errors + tb_errors + i_dut.i_chk.assert_errors;
        $display("Tests run: %0d, monitor errors: %0d, testbench errors: %0d, assertion errors: %0d",
                 tests_run, monitor_errors, tb_errors, i_dut.i_chk.assert_errors);
        if (total_errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

    ////////////////////
    // Watchdog
    ////////////////////
    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired after %0d ns, done never came", WATCHDOG_NS);
        $display("Testbench failed");
        $finish;
    end

endmodule

`default_nettype wire
